//--- verilog/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

   // way count and its binary width
   localparam int n_ways  = 4;
   localparam int nways_w = 2;

   // set count
   localparam int nlines_w = 4;
   localparam int n_lines  = 1 << nlines_w;

   // request address is {tag, line}
   localparam int tag_w  = 8;
   localparam int addr_w = tag_w + nlines_w;

   typedef logic [tag_w-1:0]    tag_t;
   typedef logic [nlines_w-1:0] line_t;
   typedef logic [addr_w-1:0]   addr_t;     // tag in the upper bits, line in the lower

   typedef logic [n_ways-1:0]   way_vec_t;  // one-hot way or valid mask
   typedef logic [nways_w-1:0]  way_idx_t;  // binary way number

   // pseudo-LRU tree of one set
   // node 1 is the root and node k has children 2k and 2k+1
   // a node at 0 sends the victim search left, at 1 it goes right
   //
   //            [1]
   //       [2]       [3]
   //     w0   w1   w2   w3
   typedef logic [n_ways-1:1]   tree_t;

endpackage

`default_nettype wire

//--- verilog/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

   // flush controller states
   typedef enum logic {
      flush_idle,   // normal lookups
      flush_sweep   // clearing one set per cycle
   } flush_state_t;

   // sweep runs from the first to the last set index
   localparam cache_geom_pkg::line_t first_line = '0;
   localparam cache_geom_pkg::line_t last_line  =
      cache_geom_pkg::line_t'(cache_geom_pkg::n_lines - 1);

endpackage

`default_nettype wire

//--- verilog/cache_dir_if.sv
`default_nettype none

// stage one to stage two, registered request plus the array read of its set
interface cache_lookup_if;
   import cache_geom_pkg::*;

   logic     vld;                 // request present in stage two
   line_t    line;
   tag_t     tag;
   tag_t     way_tags [n_ways];   // stored tag of every way
   way_vec_t way_valid;

   modport stg1 (output vld, line, tag, way_tags, way_valid);
   modport stg2 (input  vld, line, tag, way_tags, way_valid);
endinterface

// stage two back to the tag store, miss allocation
interface cache_alloc_if;
   import cache_geom_pkg::*;

   logic     wr_en;   // single-cycle write strobe
   line_t    line;
   way_vec_t way;     // one-hot target way
   tag_t     tag;

   modport src (output wr_en, line, way, tag);
   modport dst (input  wr_en, line, way, tag);
endinterface

`default_nettype wire

//--- verilog/cache_tag_store.sv
`default_nettype none

module cache_tag_store (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     flush_i,      // starts the invalidate sweep
   input  cache_geom_pkg::line_t    rd_line_i,    // set read at this edge
   output cache_geom_pkg::tag_t     rd_tags_o [cache_geom_pkg::n_ways],
   output cache_geom_pkg::way_vec_t rd_valid_o,
   output logic                     busy_o,
   cache_alloc_if.dst               alloc
);

   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;

   tag_t         tag_mem [n_ways][n_lines];   // one tag column per way
   way_vec_t     valid_mem [n_lines];         // per-set valid mask
   flush_state_t state_q;
   line_t        sweep_line_q;                // set cleared at the next edge
   logic         fwd;                         // allocation targets the set being read

   assign fwd    = alloc.wr_en && (alloc.line == rd_line_i);
   assign busy_o = (state_q == flush_sweep);

   // flush walks every set once, first_line up to last_line
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q      <= flush_idle;
         sweep_line_q <= first_line;
      end else begin
         case (state_q)
            flush_idle: begin
               if (flush_i) begin
                  state_q      <= flush_sweep;
                  sweep_line_q <= first_line;
               end
            end
            flush_sweep: begin
               if (sweep_line_q == last_line) begin
                  state_q <= flush_idle;   // last set cleared this edge
               end
               sweep_line_q <= sweep_line_q + 1'b1;
            end
            default: state_q <= flush_idle;
         endcase
      end
   end

   // valid bits, sweep clears take priority over allocation
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < n_lines; i++) begin
            valid_mem[i] <= '0;
         end
      end else if (state_q == flush_sweep) begin
         valid_mem[sweep_line_q] <= '0;
      end else if (alloc.wr_en) begin
         valid_mem[alloc.line] <= valid_mem[alloc.line] | alloc.way;   // set the new way
      end
   end

   // tag columns are only written on allocation
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < n_ways; w++) begin
         if (alloc.wr_en && alloc.way[w]) begin
            tag_mem[w][alloc.line] <= alloc.tag;
         end
      end
   end

   // registered read, write-first when stage two allocates into the same set
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < n_ways; w++) begin
         if (fwd && alloc.way[w]) begin
            rd_tags_o[w] <= alloc.tag;                 // bypass the array
         end else begin
            rd_tags_o[w] <= tag_mem[w][rd_line_i];
         end
      end
      rd_valid_o <= valid_mem[rd_line_i] | (fwd ? alloc.way : '0);
   end

   // stage two must be empty for the whole sweep
   a_no_alloc_in_sweep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q == flush_sweep) |-> !alloc.wr_en);

   a_alloc_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      alloc.wr_en |-> $onehot(alloc.way));

endmodule

`default_nettype wire

//--- verilog/cache_replacement_policy.sv
`default_nettype none

module cache_replacement_policy (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     write_en_i,        // record an access this edge
   input  cache_geom_pkg::way_vec_t way_hit_i,         // accessed way, one-hot
   input  cache_geom_pkg::line_t    line_addr_i,
   output cache_geom_pkg::way_vec_t way_select_o,      // victim, one-hot
   output cache_geom_pkg::way_idx_t way_select_bin_o   // victim, binary
);

   import cache_geom_pkg::*;

   tree_t              tree_mem [n_lines];   // one tree per set
   tree_t              tree_cur;             // tree of the addressed set
   tree_t              tree_nxt;
   logic [nways_w:0]   walk_node;            // node id during the victim walk
   logic [nways_w:0]   upd_node;             // node id along the accessed path
   way_idx_t           hit_bin;

   assign tree_cur = tree_mem[line_addr_i];   // combinational read

   // victim walk from the root, each node picks a child
   always_comb begin
      walk_node = 1;
      for (int lvl = 0; lvl < nways_w; lvl++) begin
         walk_node = {walk_node[nways_w-1:0], tree_cur[walk_node]};
      end
   end

   // leaf id minus n_ways is just the low bits
   assign way_select_bin_o = walk_node[nways_w-1:0];
   assign way_select_o     = way_vec_t'(1) << way_select_bin_o;

   always_comb begin
      hit_bin = '0;
      for (int w = 0; w < n_ways; w++) begin
         if (way_hit_i[w]) begin
            hit_bin = hit_bin | way_idx_t'(w);
         end
      end
   end

   // every node on the path now points away from the accessed way
   // msb of the way number steers the root
   always_comb begin
      tree_nxt = tree_cur;    // off-path nodes hold
      upd_node = 1;
      for (int lvl = nways_w - 1; lvl >= 0; lvl--) begin
         tree_nxt[upd_node] = ~hit_bin[lvl];
         upd_node           = {upd_node[nways_w-1:0], hit_bin[lvl]};
      end
   end

   // zero trees make way 0 the first victim
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < n_lines; i++) begin
            tree_mem[i] <= '0;
         end
      end else if (write_en_i) begin
         tree_mem[line_addr_i] <= tree_nxt;
      end
   end

   a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      write_en_i |-> $onehot(way_hit_i));

endmodule

`default_nettype wire

//--- verilog/cache_lookup_stage.sv
`default_nettype none

module cache_lookup_stage (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  req_valid_i,
   input  cache_geom_pkg::addr_t req_addr_i,
   input  logic                  flush_i,
   output logic                  busy_o,
   cache_lookup_if.stg1          lk,
   cache_alloc_if.dst            alloc
);

   import cache_geom_pkg::*;

   tag_t  req_tag;
   line_t req_line;

   // address split {tag, line}
   assign req_tag  = req_addr_i[addr_w-1:nlines_w];
   assign req_line = req_addr_i[nlines_w-1:0];

   // request valid for stage two
   // a request next to the flush pulse is dropped as well
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         lk.vld <= 1'b0;
      end else begin
         lk.vld <= req_valid_i && !busy_o && !flush_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         lk.line <= req_line;
         lk.tag  <= req_tag;
      end
   end

   // array read uses the incoming line so data and request line up in stage two
   cache_tag_store u_tag_store (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .flush_i   (flush_i),
      .rd_line_i (req_line),
      .rd_tags_o (lk.way_tags),
      .rd_valid_o(lk.way_valid),
      .busy_o    (busy_o),
      .alloc     (alloc)
   );

   // flush pulse only with stage two empty
   a_flush_pipe_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_i |-> !lk.vld);

endmodule

`default_nettype wire

//--- verilog/cache_resolve_stage.sv
`default_nettype none

module cache_resolve_stage (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   cache_lookup_if.stg2             lk,
   cache_alloc_if.src               alloc,
   output logic                     resp_valid_o,
   output logic                     resp_hit_o,
   output cache_geom_pkg::way_idx_t resp_way_o
);

   import cache_geom_pkg::*;

   way_vec_t hit_vec;
   way_vec_t free_vec;      // invalid ways of the set
   way_vec_t victim_vec;    // from the tree
   way_vec_t miss_vec;      // way to allocate on a miss
   way_vec_t access_vec;    // way touched by this request
   way_idx_t hit_bin;
   way_idx_t free_bin;      // lowest invalid way
   way_idx_t victim_bin;
   way_idx_t miss_bin;
   way_idx_t access_bin;
   logic     hit;
   logic     any_free;

   // tag compare, valid ways only
   always_comb begin
      for (int w = 0; w < n_ways; w++) begin
         hit_vec[w] = lk.way_valid[w] && (lk.way_tags[w] == lk.tag);
      end
   end

   assign hit      = |hit_vec;
   assign free_vec = ~lk.way_valid;
   assign any_free = |free_vec;

   always_comb begin
      hit_bin  = '0;
      free_bin = '0;
      for (int w = n_ways - 1; w >= 0; w--) begin
         if (hit_vec[w])  hit_bin  = way_idx_t'(w);
         if (free_vec[w]) free_bin = way_idx_t'(w);   // lowest index wins
      end
   end

   // fill empty ways before evicting
   assign miss_bin   = any_free ? free_bin : victim_bin;
   assign miss_vec   = any_free ? (way_vec_t'(1) << free_bin) : victim_vec;
   assign access_bin = hit ? hit_bin : miss_bin;
   assign access_vec = hit ? hit_vec : miss_vec;

   // allocation lands at the response edge
   assign alloc.wr_en = lk.vld && !hit;
   assign alloc.line  = lk.line;
   assign alloc.way   = miss_vec;
   assign alloc.tag   = lk.tag;

   // tree sees hits and fills alike
   cache_replacement_policy u_policy (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .write_en_i      (lk.vld),
      .way_hit_i       (access_vec),
      .line_addr_i     (lk.line),
      .way_select_o    (victim_vec),
      .way_select_bin_o(victim_bin)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= lk.vld;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lk.vld) begin
         resp_hit_o <= hit;
         resp_way_o <= access_bin;
      end
   end

   // a tag is never allocated twice in one set, so one match at most
   a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      lk.vld |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- verilog/cache_directory_top.sv
`default_nettype none

module cache_directory_top (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     req_valid_i,   // lookup strobe
   input  cache_geom_pkg::addr_t    req_addr_i,
   input  logic                     flush_i,       // invalidate all sets
   output logic                     busy_o,        // sweep in progress
   output logic                     resp_valid_o,
   output logic                     resp_hit_o,
   output cache_geom_pkg::way_idx_t resp_way_o
);

   cache_lookup_if lk_if ();      // stage one to stage two
   cache_alloc_if  alloc_if ();   // miss fill back into the arrays

   cache_lookup_stage u_lookup (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_valid_i(req_valid_i),
      .req_addr_i (req_addr_i),
      .flush_i    (flush_i),
      .busy_o     (busy_o),
      .lk         (lk_if.stg1),
      .alloc      (alloc_if.dst)
   );

   cache_resolve_stage u_resolve (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .lk          (lk_if.stg2),
      .alloc       (alloc_if.src),
      .resp_valid_o(resp_valid_o),
      .resp_hit_o  (resp_hit_o),
      .resp_way_o  (resp_way_o)
   );

endmodule

`default_nettype wire

//--- verif/cache_tb_clkgen.sv
`default_nettype none

module cache_tb_clkgen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int period     = 100;
   localparam int rst_cycles = 16;

   initial begin
      clk_o = 1'b0;
      forever #(period / 2) clk_o = ~clk_o;
   end

   // release lands just after an edge, like the other inputs
   initial begin
      rst_n_o = 1'b0;
      repeat (rst_cycles) @(posedge clk_o);
      #10 rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/cache_directory_tb.sv
`default_nettype none

module cache_directory_tb;

   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int period       = 100;
   localparam int drive_dly    = 10;                 // input skew after the rising edge
   localparam int n_rand       = 240;                // cycles of random traffic
   localparam int n_directed   = 80;                 // directed requests, idles and drains
   localparam int flush_len    = n_lines + 4;
   localparam int limit_cycles = 16 + n_directed + n_rand + flush_len + 200;

   typedef struct packed {
      logic     hit;
      way_idx_t way;
      addr_t    addr;
      int       due;    // cycle count at which the response is checked
   } resp_t;

   logic     clk;
   logic     rst_n;
   logic     req_valid;
   addr_t    req_addr;
   logic     flush;
   logic     busy;
   logic     resp_valid;
   logic     resp_hit;
   way_idx_t resp_way;

   tag_t     m_tags [n_lines][n_ways];   // reference directory
   way_vec_t m_valid [n_lines];
   tree_t    m_tree [n_lines];
   resp_t    exp_q [$];
   int       cyc = 0;
   int       hit_errs = 0;
   int       way_errs = 0;
   int       ctl_errs = 0;

   cache_tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

   cache_directory_top UUT (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .req_valid_i (req_valid),
      .req_addr_i  (req_addr),
      .flush_i     (flush),
      .busy_o      (busy),
      .resp_valid_o(resp_valid),
      .resp_hit_o  (resp_hit),
      .resp_way_o  (resp_way)
   );

   always @(posedge clk) cyc <= cyc + 1;

   // a hit wins, then the lowest invalid way, then the tree victim
   // the tree is updated on every access
   function automatic resp_t cache_model_access(addr_t addr);
      resp_t r;
      tag_t  tag;
      line_t line;
      int    way;
      int    node;
      int    lo;
      int    half;
      tag  = addr[addr_w-1:nlines_w];
      line = addr[nlines_w-1:0];
      way  = -1;
      for (int w = 0; w < n_ways; w++) begin
         if (way < 0 && m_valid[line][w] && m_tags[line][w] == tag) way = w;
      end
      r.hit = (way >= 0);
      if (!r.hit) begin
         for (int w = n_ways - 1; w >= 0; w--) begin
            if (!m_valid[line][w]) way = w;
         end
      end
      if (way < 0) begin
         node = 1;   // start at the root where 0 means go left
         while (node < n_ways) node = 2 * node + m_tree[line][node];
         way = node - n_ways;
      end
      if (!r.hit) begin
         m_tags[line][way]  = tag;
         m_valid[line][way] = 1'b1;
      end
      node = 1;
      lo   = 0;
      half = n_ways / 2;
      while (half > 0) begin
         if (way < lo + half) begin
            m_tree[line][node] = 1'b1;   // way sits on the left so point right
            node = 2 * node;
         end else begin
            m_tree[line][node] = 1'b0;
            node = 2 * node + 1;
            lo   = lo + half;
         end
         half = half / 2;
      end
      r.way  = way_idx_t'(way);
      r.addr = addr;
      r.due  = 0;
      return r;
   endfunction

   task automatic check_hit(logic got, logic exp, addr_t addr);
      if (got !== exp) begin
         hit_errs++;
         $display("CHECK FAILED at %0t: addr %h hit %b, expected %b", $time, addr, got, exp);
      end
   endtask

   task automatic check_way(way_idx_t got, way_idx_t exp, addr_t addr);
      if (got !== exp) begin
         way_errs++;
         $display("CHECK FAILED at %0t: addr %h way %0d, expected %0d", $time, addr, got, exp);
      end
   endtask

   // responses are sampled mid-cycle
   always @(negedge clk) begin : compare
      resp_t e;
      if (rst_n) begin
         if (resp_valid) begin
            if (exp_q.size() == 0) begin
               ctl_errs++;
               $display("CHECK FAILED at %0t: resp_valid_o high, no request pending", $time);
            end else begin
               e = exp_q.pop_front();
               if (e.due != cyc) begin
                  ctl_errs++;
                  $display("CHECK FAILED at %0t: addr %h answered at cycle %0d, due %0d",
                           $time, e.addr, cyc, e.due);
               end
               check_hit(resp_hit, e.hit, e.addr);
               check_way(resp_way, e.way, e.addr);
            end
         end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            e = exp_q.pop_front();
            ctl_errs++;
            $display("CHECK FAILED at %0t: resp_valid_o low, addr %h was due", $time, e.addr);
         end
      end
   end

   task automatic send_req(tag_t tag, line_t line);
      resp_t e;
      @(posedge clk);
      #drive_dly;
      req_valid = 1'b1;
      req_addr  = {tag, line};
      flush     = 1'b0;
      e     = cache_model_access({tag, line});
      e.due = cyc + 2;   // taken at the next edge and answered one edge later
      exp_q.push_back(e);
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #drive_dly;
      req_valid = 1'b0;
      flush     = 1'b0;
   endtask

   task automatic wait_drain();
      idle_cycle();
      while (exp_q.size() != 0) idle_cycle();
   endtask

   // stage two must be empty before this is called
   task automatic run_flush();
      int busy_cycles;
      busy_cycles = 0;
      @(posedge clk);
      #drive_dly;
      flush = 1'b1;
      @(posedge clk);
      #drive_dly;
      flush = 1'b0;
      for (int l = 0; l < n_lines; l++) m_valid[l] = '0;   // trees are left alone
      while (busy && busy_cycles <= n_lines) begin
         busy_cycles++;
         req_valid = 1'b1;                                   // must be ignored
         req_addr  = addr_t'($urandom);
         @(posedge clk);
         #drive_dly;
      end
      req_valid = 1'b0;
      if (busy_cycles != n_lines) begin
         ctl_errs++;
         $display("CHECK FAILED at %0t: busy_o high for %0d cycles, expected %0d",
                  $time, busy_cycles, n_lines);
      end
   endtask

   initial begin
      tag_t     old_tags [n_lines][n_ways];
      way_vec_t old_valid [n_lines];
      tag_t     evicted;
      void'($urandom(84));
      req_valid = 1'b0;
      req_addr  = '0;
      flush     = 1'b0;
      for (int l = 0; l < n_lines; l++) begin
         m_valid[l] = '0;
         m_tree[l]  = '0;
      end
      @(posedge rst_n);
      @(negedge clk);
      if (resp_valid !== 1'b0 || busy !== 1'b0) begin
         ctl_errs++;
         $display("CHECK FAILED at %0t: resp_valid_o or busy_o not low after reset", $time);
      end
      for (int w = 0; w < n_ways; w++) send_req(tag_t'(8'h40 + w), line_t'(3));   // fills 0..3
      for (int w = 0; w < n_ways; w++) send_req(tag_t'(8'h40 + w), line_t'(3));   // all hit
      wait_drain();
      send_req(8'h42, 3);
      send_req(8'h40, 3);
      send_req(8'h43, 3);
      send_req(8'h41, 3);
      send_req(8'h44, 3);                        // fifth tag evicts the tree victim
      evicted = tag_t'(8'h40 + exp_q[$].way);
      send_req(evicted, 3);
      wait_drain();
      for (int i = 0; i < 12; i++) send_req(tag_t'(8'h70 + i % 6), line_t'(7));   // back to back
      for (int i = 0; i < n_rand; i++) begin
         if ($urandom_range(3) != 0) send_req(tag_t'($urandom_range(5)), line_t'($urandom_range(2)));
         else idle_cycle();
      end
      wait_drain();
      for (int l = 0; l < n_lines; l++) begin
         old_valid[l] = m_valid[l];
         for (int w = 0; w < n_ways; w++) begin
            old_tags[l][w] = m_tags[l][w];
         end
      end
      run_flush();
      // every stored tag misses again and the refill climbs from way 0
      for (int l = 0; l <= last_line; l++) begin
         for (int w = 0; w < n_ways; w++) begin
            if (old_valid[l][w]) send_req(old_tags[l][w], line_t'(l));
         end
      end
      wait_drain();
      $display("errors: hit %0d, way %0d, protocol %0d", hit_errs, way_errs, ctl_errs);
      if (hit_errs + way_errs + ctl_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(limit_cycles * period);
      $display("timeout: run not finished after %0d cycles, %0d responses outstanding",
               limit_cycles, exp_q.size());
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
verilog/cache_geom_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/cache_dir_if.sv
verilog/cache_tag_store.sv
verilog/cache_replacement_policy.sv
verilog/cache_lookup_stage.sv
verilog/cache_resolve_stage.sv
verilog/cache_directory_top.sv
verif/cache_tb_clkgen.sv
verif/cache_directory_tb.sv
